/* Bender.yml */
package:
  name: ncpu_decode

sources:
  - files:
      - common/ncpu_pkg.sv
      - fetch/fetch_queue.sv
      - decode/insn_dec.sv
      - decode/id_stage.sv
      - verilog/rn_buffer.sv
      - verilog/ncpu_decode_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_ncpu_decode.sv

/* common/ncpu_pkg.sv */
/*
 * ncpu shared definitions
 * Instruction fields, opcodes, unit and flag encodings for the decode slice
 */
package ncpu_pkg;

   // log2 of the decode width
   localparam int ISSUE_W_P = 1;

   typedef logic [31:0] insn_t;
   typedef logic [31:0] pc_t;
   typedef logic [31:0] data_t;
   typedef logic [4:0]  lreg_t;
   typedef logic [3:0]  uop_t;
   typedef logic [3:0]  fe_t;

   // Bit positions within fe_t
   localparam int FE_FETCH = 0;
   localparam int FE_ILL   = 1;
   localparam int FE_SYS   = 2;
   localparam int FE_IRQ   = 3;

   typedef enum logic [5:0] {
      OP_ADD     = 6'd0,
      OP_SUB     = 6'd1,
      OP_AND     = 6'd2,
      OP_OR      = 6'd3,
      OP_XOR     = 6'd4,
      OP_ADDI    = 6'd8,
      OP_ANDI    = 6'd9,
      OP_LD      = 6'd16,
      OP_ST      = 6'd17,
      OP_BEQ     = 6'd24,
      OP_JAL     = 6'd25,
      OP_SYSCALL = 6'd32
   } opcode_e;

   typedef enum logic [1:0] {
      FU_ALU,
      FU_LSU,
      FU_BRU,
      FU_EPU
   } fu_e;

   // Instruction field extraction
   function automatic logic [5:0] insn_opc(insn_t insn);
      return insn[31:26];
   endfunction

   function automatic lreg_t insn_rd(insn_t insn);
      return insn[25:21];
   endfunction

   function automatic lreg_t insn_rs1(insn_t insn);
      return insn[20:16];
   endfunction

   function automatic lreg_t insn_rs2(insn_t insn);
      return insn[15:11];
   endfunction

   // 16-bit immediate, sign extended to the datapath width
   function automatic data_t insn_simm(insn_t insn);
      return {{16{insn[15]}}, insn[15:0]};
   endfunction

endpackage

/* decode/id_stage.sv */
/*
 * Decode stage
 * Decodes the queue heads slot by slot and registers them toward rename
 */
`timescale 1ns/1ps

module id_stage
#(
   parameter int P_ISSUE_WIDTH = 1
)
(
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       flush,
   input  logic                                       rn_stall_req,
   input  logic                                       irq_async,
   // From fetch queue
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]              id_valid,
   input  ncpu_pkg::insn_t [(1<<P_ISSUE_WIDTH)-1:0]   id_insn,
   input  ncpu_pkg::pc_t [(1<<P_ISSUE_WIDTH)-1:0]     id_pc,
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]              id_exc,
   output logic [P_ISSUE_WIDTH:0]                     id_pop_cnt,
   // To rename buffer
   output logic [(1<<P_ISSUE_WIDTH)-1:0]              rn_valid,
   output ncpu_pkg::fu_e [(1<<P_ISSUE_WIDTH)-1:0]     rn_fu,
   output ncpu_pkg::uop_t [(1<<P_ISSUE_WIDTH)-1:0]    rn_uop,
   output ncpu_pkg::data_t [(1<<P_ISSUE_WIDTH)-1:0]   rn_imm,
   output ncpu_pkg::pc_t [(1<<P_ISSUE_WIDTH)-1:0]     rn_pc,
   output ncpu_pkg::fe_t [(1<<P_ISSUE_WIDTH)-1:0]     rn_fe,
   output ncpu_pkg::lreg_t [(1<<P_ISSUE_WIDTH)-1:0]   rn_rs1,
   output logic [(1<<P_ISSUE_WIDTH)-1:0]              rn_rs1_re,
   output ncpu_pkg::lreg_t [(1<<P_ISSUE_WIDTH)-1:0]   rn_rs2,
   output logic [(1<<P_ISSUE_WIDTH)-1:0]              rn_rs2_re,
   output ncpu_pkg::lreg_t [(1<<P_ISSUE_WIDTH)-1:0]   rn_rd,
   output logic [(1<<P_ISSUE_WIDTH)-1:0]              rn_rd_we,
   output logic [P_ISSUE_WIDTH:0]                     rn_push_size
);
   import ncpu_pkg::*;

   localparam int IW = 1 << P_ISSUE_WIDTH;

   logic              p_ce;
   logic [IW-1:0]     fire;
   fu_e [IW-1:0]      dec_fu;
   uop_t [IW-1:0]     dec_uop;
   data_t [IW-1:0]    dec_imm;
   fe_t [IW-1:0]      dec_fe;
   logic [IW-1:0]     dec_we;
   lreg_t [IW-1:0]    dec_rd;
   logic [IW-1:0]     dec_rs1_re;
   lreg_t [IW-1:0]    dec_rs1;
   logic [IW-1:0]     dec_rs2_re;
   lreg_t [IW-1:0]    dec_rs2;

   for (genvar i = 0; i < IW; i++)
   begin : gen_dec
      insn_dec u_dec (
         .id_valid    (id_valid[i]),
         .id_insn     (id_insn[i]),
         .id_exc      (id_exc[i]),
         // Interrupts are only taken on the oldest slot
         .irq_async   ((i == 0) ? irq_async : 1'b0),
         .fu          (dec_fu[i]),
         .uop         (dec_uop[i]),
         .imm         (dec_imm[i]),
         .fe          (dec_fe[i]),
         .rf_we       (dec_we[i]),
         .rf_waddr    (dec_rd[i]),
         .rf_rs1_re   (dec_rs1_re[i]),
         .rf_rs1_addr (dec_rs1[i]),
         .rf_rs2_re   (dec_rs2_re[i]),
         .rf_rs2_addr (dec_rs2[i])
      );
   end

   assign p_ce = ~rn_stall_req;
   // Nothing is consumed while rename stalls
   assign fire = id_valid & {IW{p_ce}};

   always_comb
   begin
      id_pop_cnt = '0;
      for (int i = 0; i < IW; i++)
      begin
         id_pop_cnt = id_pop_cnt + (P_ISSUE_WIDTH+1)'(fire[i]);
      end
   end

   // Valid and size load every cycle so a held slot is never pushed twice
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rn_valid     <= '0;
         rn_push_size <= '0;
      end
      else
      begin
         rn_valid     <= fire & {IW{~flush}};
         rn_push_size <= flush ? '0 : id_pop_cnt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         rn_fu     <= dec_fu;
         rn_uop    <= dec_uop;
         rn_imm    <= dec_imm;
         rn_pc     <= id_pc;
         rn_fe     <= dec_fe;
         rn_rs1    <= dec_rs1;
         rn_rs1_re <= dec_rs1_re;
         rn_rs2    <= dec_rs2;
         rn_rs2_re <= dec_rs2_re;
         rn_rd     <= dec_rd;
         rn_rd_we  <= dec_we;
      end
   end

endmodule

/* decode/insn_dec.sv */
/*
 * Single-slot instruction decoder
 * Maps an instruction word to unit, micro-op, immediate, registers and flags
 */
`timescale 1ns/1ps

module insn_dec
(
   input  logic             id_valid,
   input  ncpu_pkg::insn_t  id_insn,
   input  logic             id_exc,
   input  logic             irq_async,
   output ncpu_pkg::fu_e    fu,
   output ncpu_pkg::uop_t   uop,
   output ncpu_pkg::data_t  imm,
   output ncpu_pkg::fe_t    fe,
   output logic             rf_we,
   output ncpu_pkg::lreg_t  rf_waddr,
   output logic             rf_rs1_re,
   output ncpu_pkg::lreg_t  rf_rs1_addr,
   output logic             rf_rs2_re,
   output ncpu_pkg::lreg_t  rf_rs2_addr
);
   import ncpu_pkg::*;

   logic [5:0] opc_raw;
   opcode_e    opc;
   logic       legal;
   logic       is_sys;
   logic       we;
   logic       re1;
   logic       re2;
   logic       use_imm;

   assign opc_raw = insn_opc(id_insn);
   assign opc     = opcode_e'(opc_raw);

   always_comb
   begin
      fu      = FU_EPU;
      legal   = 1'b1;
      is_sys  = 1'b0;
      we      = 1'b0;
      re1     = 1'b0;
      re2     = 1'b0;
      use_imm = 1'b0;
      // Fetch fault, word is not trusted
      if (id_exc)
      begin
         legal = 1'b0;
      end
      else
      begin
         case (opc)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
            begin
               fu  = FU_ALU;
               we  = 1'b1;
               re1 = 1'b1;
               re2 = 1'b1;
            end
            OP_ADDI, OP_ANDI, OP_LD:
            begin
               fu      = (opc == OP_LD) ? FU_LSU : FU_ALU;
               we      = 1'b1;
               re1     = 1'b1;
               use_imm = 1'b1;
            end
            OP_ST, OP_BEQ:
            begin
               fu      = (opc == OP_ST) ? FU_LSU : FU_BRU;
               re1     = 1'b1;
               re2     = 1'b1;
               use_imm = 1'b1;
            end
            OP_JAL:
            begin
               fu      = FU_BRU;
               we      = 1'b1;
               use_imm = 1'b1;
            end
            OP_SYSCALL:
            begin
               is_sys = 1'b1;
            end
            default:
            begin
               legal = 1'b0;
            end
         endcase
      end
   end

   assign uop = legal ? uop_t'(opc_raw[3:0]) : '0;
   assign imm = use_imm ? insn_simm(id_insn) : '0;

   always_comb
   begin
      fe           = '0;
      fe[FE_FETCH] = id_exc;
      fe[FE_ILL]   = ~legal & ~id_exc;
      fe[FE_SYS]   = is_sys;
      fe[FE_IRQ]   = irq_async & id_valid;
   end

   // r0 is hardwired, never a write target
   assign rf_waddr    = insn_rd(id_insn);
   assign rf_we       = we & id_valid & (rf_waddr != '0);
   assign rf_rs1_addr = insn_rs1(id_insn);
   assign rf_rs1_re   = re1 & id_valid;
   assign rf_rs2_addr = insn_rs2(id_insn);
   assign rf_rs2_re   = re2 & id_valid;

endmodule

/* fetch/fetch_queue.sv */
/*
 * Fetch queue
 * Circular instruction buffer that shows its oldest entries to decode
 * and retires a variable number of them per cycle
 */
`timescale 1ns/1ps

module fetch_queue
#(
   parameter int P_ISSUE_WIDTH = 1,
   parameter int P_DEPTH       = 3
)
(
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          flush,
   // Instruction source
   input  logic                                          fq_push,
   input  ncpu_pkg::insn_t                               fq_insn,
   input  ncpu_pkg::pc_t                                 fq_pc,
   input  logic                                          fq_exc,
   output logic                                          fq_full,
   // Decode side
   output logic [(1<<P_ISSUE_WIDTH)-1:0]                 id_valid,
   output ncpu_pkg::insn_t [(1<<P_ISSUE_WIDTH)-1:0]      id_insn,
   output ncpu_pkg::pc_t [(1<<P_ISSUE_WIDTH)-1:0]        id_pc,
   output logic [(1<<P_ISSUE_WIDTH)-1:0]                 id_exc,
   input  logic [P_ISSUE_WIDTH:0]                        id_pop_cnt
);
   import ncpu_pkg::*;

   localparam int IW    = 1 << P_ISSUE_WIDTH;
   localparam int DEPTH = 1 << P_DEPTH;

   insn_t              mem_insn [0:DEPTH-1];
   pc_t                mem_pc   [0:DEPTH-1];
   logic               mem_exc  [0:DEPTH-1];

   logic [P_DEPTH-1:0] head;
   logic [P_DEPTH-1:0] tail;
   logic [P_DEPTH:0]   count;
   logic               push_ok;

   assign fq_full = (count == (P_DEPTH+1)'(DEPTH));
   // A push into a full queue is dropped
   assign push_ok = fq_push & ~fq_full;

   // Payload storage
   always_ff @(posedge clk)
   begin
      if (push_ok)
      begin
         mem_insn[tail] <= fq_insn;
         mem_pc[tail]   <= fq_pc;
         mem_exc[tail]  <= fq_exc;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end
      else
      begin
         head  <= head + P_DEPTH'(id_pop_cnt);
         tail  <= tail + P_DEPTH'(push_ok);
         count <= count + (P_DEPTH+1)'(push_ok) - (P_DEPTH+1)'(id_pop_cnt);
      end
   end

   // Oldest entries, slot 0 at the head
   always_comb
   begin
      for (int i = 0; i < IW; i++)
      begin
         id_valid[i] = (count > (P_DEPTH+1)'(i));
         id_insn[i]  = mem_insn[head + P_DEPTH'(i)];
         id_pc[i]    = mem_pc[head + P_DEPTH'(i)];
         id_exc[i]   = mem_exc[head + P_DEPTH'(i)];
      end
   end

endmodule

/* ncpu_decode.f */
+incdir+testbench
common/ncpu_pkg.sv
fetch/fetch_queue.sv
decode/insn_dec.sv
decode/id_stage.sv
verilog/rn_buffer.sv
verilog/ncpu_decode_top.sv
testbench/tb_ncpu_decode.sv

/* testbench/tb_decode_model.svh */
/*
 * Decode slice testbench model
 * Random generator, reference decoder and typed compare tasks
 */
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// One expected micro-op as it should leave the rename buffer
typedef struct packed {
   pc_t   pc;
   fu_e   fu;
   uop_t  uop;
   data_t imm;
   fe_t   fe;
   lreg_t rs1;
   logic  rs1_re;
   lreg_t rs2;
   logic  rs2_re;
   lreg_t rd;
   logic  rd_we;
} uop_rec_t;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] s;
   s = x;
   s = s ^ (s << 13);
   s = s ^ (s >> 17);
   s = s ^ (s << 5);
   return s;
endfunction

function automatic uop_rec_t ref_decode(input insn_t insn, input pc_t pc, input logic exc,
                                        input logic irq);
   uop_rec_t   r;
   logic [5:0] opc;
   logic       legal;
   logic [3:0] cls;
   opc   = insn[31:26];
   legal = 1'b1;
   // Write, read rs1, read rs2, immediate used
   cls   = 4'b0000;
   r     = '0;
   r.pc  = pc;
   r.fu  = FU_EPU;
   r.rd  = insn[25:21];
   r.rs1 = insn[20:16];
   r.rs2 = insn[15:11];
   r.fe[3] = irq;
   if (exc)
   begin
      // Faulted fetch carries only the fetch flag
      r.fe[0] = 1'b1;
      legal   = 1'b0;
   end
   else
   begin
      case (opc)
         6'd0, 6'd1, 6'd2, 6'd3, 6'd4:
         begin
            r.fu = FU_ALU;
            cls  = 4'b1110;
         end
         6'd8, 6'd9:
         begin
            r.fu = FU_ALU;
            cls  = 4'b1101;
         end
         6'd16:
         begin
            r.fu = FU_LSU;
            cls  = 4'b1101;
         end
         6'd17:
         begin
            r.fu = FU_LSU;
            cls  = 4'b0111;
         end
         6'd24:
         begin
            r.fu = FU_BRU;
            cls  = 4'b0111;
         end
         6'd25:
         begin
            r.fu = FU_BRU;
            cls  = 4'b1001;
         end
         6'd32:
            r.fe[2] = 1'b1;
         default:
         begin
            r.fe[1] = 1'b1;
            legal   = 1'b0;
         end
      endcase
   end
   r.uop    = legal ? opc[3:0] : 4'd0;
   r.rd_we  = cls[3] & (r.rd != 5'd0);
   r.rs1_re = cls[2];
   r.rs2_re = cls[1];
   r.imm    = cls[0] ? {{16{insn[15]}}, insn[15:0]} : 32'd0;
   return r;
endfunction

task automatic report_mismatch(input string field, input string exp_s, input string act_s);
   $display("Error: %s %s expected %s actual %s", cur_test, field, exp_s, act_s);
   err_cnt++;
endtask

task automatic compare_fu(input string field, input fu_e exp, input fu_e act);
   if (exp !== act)
      report_mismatch(field, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic compare_uop(input string field, input uop_t exp, input uop_t act);
   if (exp !== act)
      report_mismatch(field, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic compare_imm(input string field, input data_t exp, input data_t act);
   if (exp !== act)
      report_mismatch(field, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic compare_reg(input string field, input lreg_t exp, input lreg_t act);
   if (exp !== act)
      report_mismatch(field, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic compare_fe(input string field, input fe_t exp, input fe_t act);
   if (exp !== act)
      report_mismatch(field, $sformatf("%b", exp), $sformatf("%b", act));
endtask

task automatic compare_pc(input string field, input pc_t exp, input pc_t act);
   if (exp !== act)
      report_mismatch(field, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic compare_bit(input string field, input logic exp, input logic act);
   if (exp !== act)
      report_mismatch(field, $sformatf("%b", exp), $sformatf("%b", act));
endtask

`endif

/* testbench/tb_ncpu_decode.sv */
/*
 * Decode slice testbench
 * Random instruction streams checked in order against a reference decoder
 */
`timescale 1ns/1ps

module tb_ncpu_decode;
   import ncpu_pkg::*;

   localparam int          CLK_PERIOD = 20;
   localparam logic [31:0] SEED       = 32'h0d62_9cc4;
   localparam int N_ALU     = 40;
   localparam int N_IMM     = 40;
   localparam int N_EXC     = 30;
   localparam int N_BP      = 100;
   localparam int N_FLUSH   = 8;
   localparam int N_FRESH   = 12;
   localparam int N_IRQ     = 5;
   localparam int N_PUSH    = N_ALU + N_IMM + N_EXC + N_BP + N_FLUSH + N_FRESH + N_IRQ;
   localparam int WD_CYCLES = 40 * N_PUSH + 200;

   logic  clk;
   logic  rst_n;
   logic  flush;
   logic  irq_async;
   logic  fq_push;
   insn_t fq_insn;
   pc_t   fq_pc;
   logic  fq_exc;
   logic  fq_full;
   logic  out_ready;
   logic  out_valid;
   pc_t   out_pc;
   fu_e   out_fu;
   uop_t  out_uop;
   data_t out_imm;
   fe_t   out_fe;
   lreg_t out_rs1;
   logic  out_rs1_re;
   lreg_t out_rs2;
   logic  out_rs2_re;
   lreg_t out_rd;
   logic  out_rd_we;

   string cur_test;
   int    err_cnt;

`include "tb_decode_model.svh"

   uop_rec_t    exp_q[$];
   int          test_err_base;
   int          tests_run;
   int          tests_failed;
   int          checked;
   logic [31:0] rng_state;
   logic [31:0] rdy_state;
   logic        rand_ready;
   pc_t         pc_next;
   logic [5:0]  legal_list [0:11] = '{6'd0, 6'd1, 6'd2, 6'd3, 6'd4, 6'd8, 6'd9,
                                      6'd16, 6'd17, 6'd24, 6'd25, 6'd32};

   ncpu_decode_top #(
      .P_ISSUE_WIDTH (ISSUE_W_P),
      .FQ_DEPTH_P    (3),
      .RB_DEPTH_P    (3)
   ) DUT (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] rand32();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic logic is_legal_opc(input logic [5:0] opc);
      return (opc <= 6'd4) || (opc == 6'd8) || (opc == 6'd9) || (opc == 6'd16) ||
             (opc == 6'd17) || (opc == 6'd24) || (opc == 6'd25) || (opc == 6'd32);
   endfunction

   // Random register fields and immediate under a fixed opcode
   function automatic insn_t make_insn(input logic [5:0] opc);
      logic [31:0] r;
      r = rand32();
      return {opc, r[25:0]};
   endfunction

   function automatic logic [5:0] illegal_opc();
      logic [31:0] r;
      r = rand32();
      while (is_legal_opc(r[5:0]))
         r = rand32();
      return r[5:0];
   endfunction

   // Called at 2 ns after a rising edge, returns at the same phase
   task automatic push_insn(input insn_t insn, input logic exc);
      while (fq_full)
      begin
         @(posedge clk);
         #2;
      end
      fq_push = 1'b1;
      fq_insn = insn;
      fq_pc   = pc_next;
      fq_exc  = exc;
      exp_q.push_back(ref_decode(insn, pc_next, exc, irq_async));
      pc_next = pc_next + 32'd4;
      @(posedge clk);
      #2;
      fq_push = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      int limit;
      n     = 0;
      limit = 40 * exp_q.size() + 50;
      while (exp_q.size() != 0 && n < limit)
      begin
         @(posedge clk);
         #2;
         n++;
      end
      if (exp_q.size() != 0)
      begin
         $display("%0d micro-ops never came out in test %s", exp_q.size(), cur_test);
         err_cnt += exp_q.size();
         exp_q.delete();
      end
   endtask

   task automatic check_uop(input uop_rec_t e);
      compare_pc("pc", e.pc, out_pc);
      compare_fu("fu", e.fu, out_fu);
      compare_uop("uop", e.uop, out_uop);
      compare_imm("imm", e.imm, out_imm);
      compare_fe("fe", e.fe, out_fe);
      compare_reg("rs1", e.rs1, out_rs1);
      compare_bit("rs1_re", e.rs1_re, out_rs1_re);
      compare_reg("rs2", e.rs2, out_rs2);
      compare_bit("rs2_re", e.rs2_re, out_rs2_re);
      compare_reg("rd", e.rd, out_rd);
      compare_bit("rd_we", e.rd_we, out_rd_we);
   endtask

   task automatic begin_test(input string name);
      cur_test      = name;
      test_err_base = err_cnt;
      tests_run++;
   endtask

   task automatic end_test();
      if (err_cnt == test_err_base)
         $display("Test %s: ok", cur_test);
      else
      begin
         tests_failed++;
         $display("Test %s: %0d errors", cur_test, err_cnt - test_err_base);
      end
   endtask

   // Output side sampled mid-cycle, a transfer happens at the next rising edge
   always @(negedge clk)
   begin
      if (rst_n && out_valid && out_ready)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Extra micro-op at pc %h in test %s", out_pc, cur_test);
            err_cnt++;
         end
         else
         begin
            check_uop(exp_q.pop_front());
            checked++;
         end
      end
   end

   // Consumer back-pressure, own random stream
   always @(posedge clk)
   begin
      #2;
      if (rand_ready)
      begin
         rdy_state = xorshift32(rdy_state);
         out_ready = (rdy_state % 10) < 3;
      end
   end

   initial
   begin
      #(WD_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      insn_t       insn;
      logic [31:0] r;
      clk          = 1'b0;
      rst_n        = 1'b0;
      flush        = 1'b0;
      irq_async    = 1'b0;
      fq_push      = 1'b0;
      fq_insn      = '0;
      fq_pc        = '0;
      fq_exc       = 1'b0;
      out_ready    = 1'b0;
      rand_ready   = 1'b0;
      rng_state    = SEED;
      rdy_state    = ~SEED;
      pc_next      = 32'h0000_1000;
      err_cnt      = 0;
      tests_run    = 0;
      tests_failed = 0;
      checked      = 0;
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;

      begin_test("reset");
      compare_bit("fq_full", 1'b0, fq_full);
      compare_bit("out_valid", 1'b0, out_valid);
      end_test();
      out_ready = 1'b1;

      begin_test("alu_reg");
      for (int i = 0; i < N_ALU; i++)
      begin
         insn = make_insn(legal_list[rand32() % 5]);
         if (i % 8 == 0)
            insn[25:21] = 5'd0;
         push_insn(insn, 1'b0);
      end
      wait_drain();
      end_test();

      begin_test("imm_mem_branch");
      for (int i = 0; i < N_IMM; i++)
         push_insn(make_insn(legal_list[5 + rand32() % 6]), 1'b0);
      wait_drain();
      end_test();

      begin_test("exceptions");
      for (int i = 0; i < N_EXC; i++)
      begin
         case (i % 3)
            0: push_insn(make_insn(illegal_opc()), 1'b0);
            1: push_insn(make_insn(6'd32), 1'b0);
            default: push_insn(make_insn(legal_list[rand32() % 12]), 1'b1);
         endcase
      end
      wait_drain();
      end_test();

      begin_test("backpressure");
      rand_ready = 1'b1;
      for (int i = 0; i < N_BP; i++)
      begin
         r = rand32();
         if (r[3:0] == 4'd0)
            push_insn(make_insn(illegal_opc()), 1'b0);
         else
            push_insn(make_insn(legal_list[r[31:8] % 12]), r[7:4] == 4'd0);
      end
      wait_drain();
      rand_ready = 1'b0;
      out_ready  = 1'b1;
      end_test();

      begin_test("flush");
      out_ready = 1'b0;
      for (int i = 0; i < N_FLUSH; i++)
         push_insn(make_insn(legal_list[rand32() % 12]), 1'b0);
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush = 1'b0;
      exp_q.delete();
      out_ready = 1'b1;
      repeat (10)
      begin
         @(negedge clk);
         if (out_valid)
         begin
            $display("out_valid went high after flush in test %s", cur_test);
            err_cnt++;
         end
      end
      @(posedge clk);
      #2;
      for (int i = 0; i < N_FRESH; i++)
         push_insn(make_insn(legal_list[rand32() % 12]), 1'b0);
      wait_drain();
      end_test();

      // Lone instruction decodes in slot 0 with the interrupt pending
      begin_test("interrupt");
      irq_async = 1'b1;
      push_insn(make_insn(legal_list[rand32() % 12]), 1'b0);
      wait_drain();
      irq_async = 1'b0;
      for (int i = 1; i < N_IRQ; i++)
         push_insn(make_insn(legal_list[rand32() % 12]), 1'b0);
      wait_drain();
      end_test();

      $display("Tests run: %0d, failed: %0d, micro-ops checked: %0d, errors: %0d",
               tests_run, tests_failed, checked, err_cnt);
      if (err_cnt == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* verilog/ncpu_decode_top.sv */
/*
 * Decode slice top level
 * Fetch queue, two-wide decode stage and rename buffer in one pipeline
 */
`timescale 1ns/1ps

module ncpu_decode_top
#(
   parameter int P_ISSUE_WIDTH = ncpu_pkg::ISSUE_W_P,
   parameter int FQ_DEPTH_P    = 3,
   parameter int RB_DEPTH_P    = 3
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              flush,
   input  logic              irq_async,
   // Instruction source
   input  logic              fq_push,
   input  ncpu_pkg::insn_t   fq_insn,
   input  ncpu_pkg::pc_t     fq_pc,
   input  logic              fq_exc,
   output logic              fq_full,
   // Micro-op sink
   input  logic              out_ready,
   output logic              out_valid,
   output ncpu_pkg::pc_t     out_pc,
   output ncpu_pkg::fu_e     out_fu,
   output ncpu_pkg::uop_t    out_uop,
   output ncpu_pkg::data_t   out_imm,
   output ncpu_pkg::fe_t     out_fe,
   output ncpu_pkg::lreg_t   out_rs1,
   output logic              out_rs1_re,
   output ncpu_pkg::lreg_t   out_rs2,
   output logic              out_rs2_re,
   output ncpu_pkg::lreg_t   out_rd,
   output logic              out_rd_we
);
   import ncpu_pkg::*;

   localparam int IW = 1 << P_ISSUE_WIDTH;

   // Queue heads toward decode
   logic [IW-1:0]          id_valid;
   insn_t [IW-1:0]         id_insn;
   pc_t [IW-1:0]           id_pc;
   logic [IW-1:0]          id_exc;
   logic [P_ISSUE_WIDTH:0] id_pop_cnt;

   // Registered decode slots
   logic [IW-1:0]          rn_valid;
   fu_e [IW-1:0]           rn_fu;
   uop_t [IW-1:0]          rn_uop;
   data_t [IW-1:0]         rn_imm;
   pc_t [IW-1:0]           rn_pc;
   fe_t [IW-1:0]           rn_fe;
   lreg_t [IW-1:0]         rn_rs1;
   logic [IW-1:0]          rn_rs1_re;
   lreg_t [IW-1:0]         rn_rs2;
   logic [IW-1:0]          rn_rs2_re;
   lreg_t [IW-1:0]         rn_rd;
   logic [IW-1:0]          rn_rd_we;
   logic [P_ISSUE_WIDTH:0] rn_push_size;
   logic                   rn_stall_req;

   fetch_queue #(.P_ISSUE_WIDTH(P_ISSUE_WIDTH), .P_DEPTH(FQ_DEPTH_P)) u_fetch_queue (.*);

   id_stage #(.P_ISSUE_WIDTH(P_ISSUE_WIDTH)) u_id_stage (.*);

   rn_buffer #(.P_ISSUE_WIDTH(P_ISSUE_WIDTH), .P_DEPTH(RB_DEPTH_P)) u_rn_buffer (.*);

endmodule

/* verilog/rn_buffer.sv */
/*
 * Rename buffer
 * Collects decoded slots in order and releases one micro-op per cycle
 */
`timescale 1ns/1ps

module rn_buffer
#(
   parameter int P_ISSUE_WIDTH = 1,
   parameter int P_DEPTH       = 3
)
(
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       flush,
   // From decode stage
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]              rn_valid,
   input  ncpu_pkg::fu_e [(1<<P_ISSUE_WIDTH)-1:0]     rn_fu,
   input  ncpu_pkg::uop_t [(1<<P_ISSUE_WIDTH)-1:0]    rn_uop,
   input  ncpu_pkg::data_t [(1<<P_ISSUE_WIDTH)-1:0]   rn_imm,
   input  ncpu_pkg::pc_t [(1<<P_ISSUE_WIDTH)-1:0]     rn_pc,
   input  ncpu_pkg::fe_t [(1<<P_ISSUE_WIDTH)-1:0]     rn_fe,
   input  ncpu_pkg::lreg_t [(1<<P_ISSUE_WIDTH)-1:0]   rn_rs1,
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]              rn_rs1_re,
   input  ncpu_pkg::lreg_t [(1<<P_ISSUE_WIDTH)-1:0]   rn_rs2,
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]              rn_rs2_re,
   input  ncpu_pkg::lreg_t [(1<<P_ISSUE_WIDTH)-1:0]   rn_rd,
   input  logic [(1<<P_ISSUE_WIDTH)-1:0]              rn_rd_we,
   input  logic [P_ISSUE_WIDTH:0]                     rn_push_size,
   output logic                                       rn_stall_req,
   // Micro-op output
   input  logic                                       out_ready,
   output logic                                       out_valid,
   output ncpu_pkg::pc_t                              out_pc,
   output ncpu_pkg::fu_e                              out_fu,
   output ncpu_pkg::uop_t                             out_uop,
   output ncpu_pkg::data_t                            out_imm,
   output ncpu_pkg::fe_t                              out_fe,
   output ncpu_pkg::lreg_t                            out_rs1,
   output logic                                       out_rs1_re,
   output ncpu_pkg::lreg_t                            out_rs2,
   output logic                                       out_rs2_re,
   output ncpu_pkg::lreg_t                            out_rd,
   output logic                                       out_rd_we
);
   import ncpu_pkg::*;

   localparam int IW    = 1 << P_ISSUE_WIDTH;
   localparam int DEPTH = 1 << P_DEPTH;
   localparam int ENT_W = $bits(pc_t) + $bits(fu_e) + $bits(uop_t) + $bits(data_t)
                          + $bits(fe_t) + 3 * $bits(lreg_t) + 3;

   logic [ENT_W-1:0]        mem [0:DEPTH-1];
   logic [P_DEPTH-1:0]      head;
   logic [P_DEPTH-1:0]      tail;
   logic [P_DEPTH:0]        count;
   logic [P_DEPTH:0]        free;
   logic                    pop;
   logic [$bits(fu_e)-1:0]  head_fu;

   // Slots arrive packed from slot 0, so slot i lands at tail + i
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < IW; i++)
      begin
         if (rn_valid[i])
         begin
            mem[tail + P_DEPTH'(i)] <= {rn_pc[i], rn_fu[i], rn_uop[i], rn_imm[i], rn_fe[i],
                                        rn_rs1[i], rn_rs1_re[i], rn_rs2[i], rn_rs2_re[i],
                                        rn_rd[i], rn_rd_we[i]};
         end
      end
   end

   assign out_valid = (count != '0);
   assign pop       = out_valid & out_ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end
      else
      begin
         head  <= head + P_DEPTH'(pop);
         tail  <= tail + P_DEPTH'(rn_push_size);
         count <= count + (P_DEPTH+1)'(rn_push_size) - (P_DEPTH+1)'(pop);
      end
   end

   // Free space counts the slots still in the decode register as taken
   assign free         = (P_DEPTH+1)'(DEPTH) - count - (P_DEPTH+1)'(rn_push_size);
   assign rn_stall_req = (free < (P_DEPTH+1)'(2));

   assign {out_pc, head_fu, out_uop, out_imm, out_fe, out_rs1, out_rs1_re,
           out_rs2, out_rs2_re, out_rd, out_rd_we} = mem[head];
   assign out_fu = fu_e'(head_fu);

endmodule
